// ==== sim.f ====
rtl/image_geom_pkg.sv
rtl/stream_ctrl_pkg.sv
rtl/image_beat_if.sv
rtl/frame_header_ctrl.sv
rtl/stream_slice.sv
rtl/column_shift_buffer.sv
rtl/image_pipe_top.sv
verif/image_pipe_props.sv
verif/image_pipe_checker.sv
verif/tb_image_pipe.sv

// ==== Makefile ====
TOP = tb_image_pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_image_pipe.sv ====
// Image column pipe testbench

module tb_image_pipe;

  timeunit 1ns;
  timeprecision 1ps;

  import image_geom_pkg::*;
  import stream_ctrl_pkg::*;

  localparam int W           = DEF_WORD_WIDTH;
  localparam int UNITS_EDGES = padded_words(DEF_UNITS, DEF_KH_MAX);
  localparam int DW          = W * UNITS_EDGES;
  localparam int WAIT_MAX    = 2000;  // cycles per handshake wait
  localparam int NUM_FRAMES  = 8;

  typedef struct packed {
    int is_max;
    int kh2;
    int beats;      // data beats after the header
    int stall_pct;  // percent of cycles with m_ready low
    int exp_outs;   // beats * (2*kh2 + 1)
  } frame_row_t;

  // ****************************************
  // frame table
  // ****************************************
  frame_row_t frames [NUM_FRAMES] = '{
    '{0, 0, 3, 0, 3},
    '{0, 1, 3, 0, 9},
    '{0, 2, 2, 0, 10},
    '{1, 0, 3, 0, 3},
    '{1, 1, 3, 30, 9},
    '{1, 2, 4, 50, 20},
    '{0, 2, 3, 40, 15},
    '{1, 1, 2, 0, 6}
  };

  logic                            aclk = 1'b0;
  logic                            arst_n;
  logic                            s1_valid;
  logic                            s1_ready;
  logic [DW-1:0]                   s1_data;
  logic                            s1_last;
  logic                            s2_valid;
  logic                            s2_ready;
  logic [DW-1:0]                   s2_data;
  logic                            m_valid;
  logic                            m_ready;
  logic [W*DEF_UNITS-1:0]          m_data_1;
  logic [W*DEF_UNITS-1:0]          m_data_2;
  logic [kh2_bits(DEF_KH_MAX)-1:0] m_kh2;
  int                              errors;
  int                              checked;
  int                              pending;
  int unsigned                     lcg_state = 42;
  int                              stall_pct;
  bit                              timed_out;

  always #50 aclk = ~aclk;

  image_pipe_top #(.UNITS(DEF_UNITS), .KH_MAX(DEF_KH_MAX), .WORD_WIDTH(W)) u_dut (
    .aclk, .arst_n, .s1_valid, .s1_ready, .s1_data, .s1_last, .s2_valid, .s2_ready,
    .s2_data, .m_valid, .m_ready, .m_data_1, .m_data_2, .m_kh2
  );

  image_pipe_checker #(.UNITS(DEF_UNITS), .KH_MAX(DEF_KH_MAX), .WORD_WIDTH(W)) u_check (
    .aclk, .arst_n, .s1_valid, .s1_ready, .s1_data, .s1_last, .s2_valid, .s2_ready,
    .s2_data, .m_valid, .m_ready, .m_data_1, .m_data_2, .m_kh2, .errors, .checked, .pending
  );

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // low bits of an lcg repeat quickly
  endfunction

  function automatic logic [DW-1:0] rand_beat();
    logic [DW-1:0] d;
    for (int i = 0; i < UNITS_EDGES; i++) begin
      d[i*W +: W] = W'(next_rand());
    end
    return d;
  endfunction

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timed_out = 1'b1;
  endtask

  // step to the falling edge and draw m_ready for the next cycle
  task automatic tick();
    @(negedge aclk);
    m_ready = (next_rand() % 100) >= stall_pct;
  endtask

  // ****************************************
  // one beat on s1 joined with s2 if paired
  // ****************************************
  task automatic send_beat(input logic [DW-1:0] d1, input logic last, input logic paired);
    int n;
    int lag1;
    int lag2;
    bit f1;
    bit f2;
    bit s1_done;
    bit s2_done;
    lag1     = paired ? int'(next_rand() % 3) : 0;  // cycles before each stream is offered
    lag2     = paired ? int'(next_rand() % 3) : 0;
    s1_data  = d1;
    s1_last  = last;
    s1_valid = (lag1 == 0);
    if (paired) begin
      s2_data  = rand_beat();
      s2_valid = (lag2 == 0);
    end
    s1_done = 1'b0;
    s2_done = !paired;
    for (n = 0; n < WAIT_MAX && !(s1_done && s2_done); n++) begin
      @(posedge aclk);
      f1 = s1_valid && s1_ready;
      f2 = s2_valid && s2_ready;
      s1_done |= f1;
      s2_done |= f2;
      tick();
      if (f1) s1_valid = 1'b0;
      if (f2) s2_valid = 1'b0;
      if (n + 1 == lag1) s1_valid = 1'b1;  // late stream joins now
      if (n + 1 == lag2) s2_valid = 1'b1;
    end
    if (!(s1_done && s2_done)) begin
      report_timeout("an input handshake");
    end
  endtask

  task automatic run_frame(input frame_row_t row);
    logic [DW-1:0] hdr;
    hdr = rand_beat();  // reserved word stays random
    hdr[IDX_IS_MAX*W +: W] = W'(row.is_max);
    hdr[IDX_KH2*W +: W]    = W'(row.kh2);
    stall_pct = row.stall_pct;
    s2_data   = rand_beat();
    s2_valid  = (row.is_max == 0);  // junk offered that must stay unread
    send_beat(hdr, 1'b0, 1'b0);
    for (int b = 0; b < row.beats && !timed_out; b++) begin
      send_beat(rand_beat(), b == row.beats - 1, row.is_max != 0);
    end
    s2_valid = 1'b0;
  endtask

  initial begin
    int total_exp;
    int fails;
    int n;
    arst_n    = 1'b0;
    s1_valid  = 1'b0;
    s1_data   = '0;
    s1_last   = 1'b0;
    s2_valid  = 1'b0;
    s2_data   = '0;
    m_ready   = 1'b0;
    stall_pct = 0;
    total_exp = 0;
    timed_out = 1'b0;
    repeat (16) @(negedge aclk);
    arst_n = 1'b1;
    for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
      total_exp += frames[f].exp_outs;
      run_frame(frames[f]);  // next header follows at once
    end
    stall_pct = 0;
    for (n = 0; n < WAIT_MAX && pending != 0 && !timed_out; n++) begin
      tick();
    end
    if (pending != 0 && !timed_out) begin
      report_timeout("the output to drain");
    end
    if (timed_out) begin
      $display("Test FAILED");
    end else begin
      repeat (10) tick();  // catch stray extra beats
      fails = errors + int'(checked != total_exp);
      if (checked != total_exp) begin
        $display("Mismatch out_beats exp 0x%0h got 0x%0h", total_exp, checked);
      end
      $display("frames %0d, output beats %0d, errors %0d", NUM_FRAMES, checked, fails);
      if (fails == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
    end
    $finish;
  end

endmodule

// ==== verif/image_pipe_checker.sv ====
// Image pipe output checker

module image_pipe_checker #(
  parameter int UNITS      = image_geom_pkg::DEF_UNITS,
  parameter int KH_MAX     = image_geom_pkg::DEF_KH_MAX,
  parameter int WORD_WIDTH = image_geom_pkg::DEF_WORD_WIDTH
) (
  input  logic aclk,
  input  logic arst_n,
  input  logic s1_valid,
  input  logic s1_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s1_data,
  input  logic s1_last,
  input  logic s2_valid,
  input  logic s2_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s2_data,
  input  logic m_valid,
  input  logic m_ready,
  input  logic [WORD_WIDTH*UNITS-1:0] m_data_1,
  input  logic [WORD_WIDTH*UNITS-1:0] m_data_2,
  input  logic [image_geom_pkg::kh2_bits(KH_MAX)-1:0] m_kh2,
  output int   errors,
  output int   checked,
  output int   pending
);

  timeunit 1ns;
  timeprecision 1ps;

  import image_geom_pkg::*;
  import stream_ctrl_pkg::*;

  localparam int UNITS_EDGES = padded_words(UNITS, KH_MAX);
  localparam int OUT_BITS    = WORD_WIDTH * UNITS;

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] words_t;
  typedef logic [UNITS-1:0][WORD_WIDTH-1:0]       out_t;

  out_t exp_1_q[$];
  out_t exp_2_q[$];
  int   exp_kh2_q[$];
  bit   exp_end_q[$];  // last output beat of a frame
  bit   in_hdr = 1'b1;
  bit   is_max;
  int   kh2;
  int   frame_no;
  int   frame_outs;
  int   frame_err;

  task automatic flag(input string msg);
    $display("ERROR: %s", msg);
    errors++;
    frame_err++;
  endtask

  task automatic compare(input string name, input logic [OUT_BITS-1:0] exp,
                         input logic [OUT_BITS-1:0] got);
    if (got !== exp) begin
      $display("Mismatch %s exp 0x%0h got 0x%0h", name, exp, got);
      errors++;
      frame_err++;
    end
  endtask

  always @(posedge aclk) begin
    words_t w1;
    words_t w2;
    out_t   e1;
    out_t   e2;
    bit     s1_fire;
    bit     s2_fire;
    s1_fire = s1_valid && s1_ready;
    s2_fire = s2_valid && s2_ready;
    if (!arst_n) begin
      in_hdr = 1'b1;
    end else begin
      // ****************************************
      // output side
      // ****************************************
      if (m_valid && m_ready && exp_1_q.size() == 0) begin
        flag("output beat with no input beat left to match");
      end else if (m_valid && m_ready) begin
        compare("m_data_1", exp_1_q.pop_front(), m_data_1);
        compare("m_data_2", exp_2_q.pop_front(), m_data_2);
        compare("m_kh2", OUT_BITS'(exp_kh2_q.pop_front()), OUT_BITS'(m_kh2));
        checked++;
        frame_outs++;
        if (exp_end_q.pop_front()) begin
          $display("frame %0d done, %0d output beats, %0d errors",
                   frame_no, frame_outs, frame_err);
          frame_no++;
          frame_outs = 0;
          frame_err  = 0;
        end
      end
      // ****************************************
      // input side
      // ****************************************
      if ((in_hdr || !is_max) && s2_ready) begin
        flag("s2_ready high outside a max-mode data beat");
      end
      if (!in_hdr && is_max && s1_fire != s2_fire) begin
        flag("stream 1 and stream 2 taken in different cycles");
      end
      w1 = s1_data;
      if (s1_fire && in_hdr) begin
        is_max = w1[IDX_IS_MAX][0];
        kh2    = int'(w1[IDX_KH2]);
        in_hdr = 1'b0;
      end else if (s1_fire) begin
        w2 = is_max ? s2_data : s1_data;
        for (int j = 0; j <= 2 * kh2; j++) begin
          for (int u = 0; u < UNITS; u++) begin
            e1[u] = w1[u + j + KH_MAX / 2 - kh2];  // de-centered, j words up
            e2[u] = w2[u + j + KH_MAX / 2 - kh2];
          end
          exp_1_q.push_back(e1);
          exp_2_q.push_back(e2);
          exp_kh2_q.push_back(kh2);
          exp_end_q.push_back(s1_last && j == 2 * kh2);
        end
        in_hdr = s1_last;  // next s1 beat is a header
      end
      pending = exp_1_q.size();
    end
  end

endmodule

// ==== verif/image_pipe_props.sv ====
// Output handshake properties

module image_pipe_props #(
  parameter int DATA_BITS = 32,
  parameter int KH2_BITS  = 2
) (
  input logic                 aclk,
  input logic                 arst_n,
  input logic                 m_valid,
  input logic                 m_ready,
  input logic [DATA_BITS-1:0] m_data_1,
  input logic [DATA_BITS-1:0] m_data_2,
  input logic [KH2_BITS-1:0]  m_kh2
);

  timeunit 1ns;
  timeprecision 1ps;

  // nothing leaves the pipe while reset holds
  assert property (@(posedge aclk) !arst_n |-> !m_valid)
    else $error("m_valid high during reset");

  // a stalled beat keeps valid and payload
  assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data_1) && $stable(m_data_2) &&
                            $stable(m_kh2))
    else $error("output beat changed while stalled");

endmodule

bind image_pipe_top image_pipe_props #(
  .DATA_BITS (WORD_WIDTH * UNITS),
  .KH2_BITS  (KH2_BITS)
) u_props (
  .aclk     (aclk),
  .arst_n   (arst_n),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_data_1 (m_data_1),
  .m_data_2 (m_data_2),
  .m_kh2    (m_kh2)
);

// ==== rtl/image_pipe_top.sv ====
// Image column pipe top level

module image_pipe_top #(
  parameter int UNITS      = image_geom_pkg::DEF_UNITS,
  parameter int KH_MAX     = image_geom_pkg::DEF_KH_MAX,
  parameter int WORD_WIDTH = image_geom_pkg::DEF_WORD_WIDTH
) (
  input  logic aclk,
  input  logic arst_n,
  input  logic s1_valid,
  output logic s1_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s1_data,
  input  logic s1_last,
  input  logic s2_valid,
  output logic s2_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s2_data,
  output logic m_valid,
  input  logic m_ready,
  output logic [WORD_WIDTH*UNITS-1:0] m_data_1,
  output logic [WORD_WIDTH*UNITS-1:0] m_data_2,
  output logic [image_geom_pkg::kh2_bits(KH_MAX)-1:0] m_kh2
);

  import image_geom_pkg::*;

  localparam int UNITS_EDGES = padded_words(UNITS, KH_MAX);
  localparam int KH2_BITS    = kh2_bits(KH_MAX);

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] padded_lane_t;
  typedef logic [UNITS-1:0][WORD_WIDTH-1:0]       out_lane_t;

  image_beat_if #(.lane_t(padded_lane_t), .KH2_BITS(KH2_BITS)) hdr_beat ();
  image_beat_if #(.lane_t(padded_lane_t), .KH2_BITS(KH2_BITS)) slice_beat ();
  image_beat_if #(.lane_t(out_lane_t), .KH2_BITS(KH2_BITS))    shift_beat ();
  image_beat_if #(.lane_t(out_lane_t), .KH2_BITS(KH2_BITS))    out_beat ();

  frame_header_ctrl #(.UNITS(UNITS), .KH_MAX(KH_MAX), .WORD_WIDTH(WORD_WIDTH)) u_hdr (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .s1_valid (s1_valid),
    .s1_ready (s1_ready),
    .s1_data  (s1_data),
    .s1_last  (s1_last),
    .s2_valid (s2_valid),
    .s2_ready (s2_ready),
    .s2_data  (s2_data),
    .out      (hdr_beat.source)
  );

  stream_slice #(.lane_t(padded_lane_t), .KH2_BITS(KH2_BITS)) u_hdr_slice (
    .aclk   (aclk),
    .arst_n (arst_n),
    .in     (hdr_beat.sink),
    .out    (slice_beat.source)
  );

  column_shift_buffer #(.UNITS(UNITS), .KH_MAX(KH_MAX), .WORD_WIDTH(WORD_WIDTH)) u_shift (
    .aclk   (aclk),
    .arst_n (arst_n),
    .in     (slice_beat.sink),
    .out    (shift_beat.source)
  );

  stream_slice #(.lane_t(out_lane_t), .KH2_BITS(KH2_BITS)) u_out_slice (
    .aclk   (aclk),
    .arst_n (arst_n),
    .in     (shift_beat.sink),
    .out    (out_beat.source)
  );

  assign out_beat.ready = m_ready;
  assign m_valid        = out_beat.valid;
  assign m_data_1       = out_beat.lane_1;
  assign m_data_2       = out_beat.lane_2;
  assign m_kh2          = out_beat.kh2;

endmodule

// ==== rtl/column_shift_buffer.sv ====
// Column shift buffer

module column_shift_buffer #(
  parameter int UNITS      = image_geom_pkg::DEF_UNITS,
  parameter int KH_MAX     = image_geom_pkg::DEF_KH_MAX,
  parameter int WORD_WIDTH = image_geom_pkg::DEF_WORD_WIDTH
) (
  input  logic         aclk,
  input  logic         arst_n,
  image_beat_if.sink   in,
  image_beat_if.source out
);

  import image_geom_pkg::*;

  localparam int UNITS_EDGES = padded_words(UNITS, KH_MAX);
  localparam int KH2_BITS    = kh2_bits(KH_MAX);
  localparam int CNT_BITS    = (KH_MAX > 1) ? $clog2(KH_MAX) : 1;  // holds 2*kh2

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] words_t;

  words_t              in_1;
  words_t              in_2;
  words_t              ld_1;
  words_t              ld_2;
  words_t              buf_1_q;
  words_t              buf_2_q;
  logic [KH2_BITS-1:0] kh2_q;
  logic [CNT_BITS-1:0] cnt_q;
  logic                valid_q;

  assign in_1 = in.lane_1;
  assign in_2 = in.lane_2;

  // ****************************************
  // de-centering on load
  // ****************************************
  // word i takes input word i + KH_MAX/2 - kh2, so the window starts at the
  // first edge word the kernel needs and shifts upward from there
  always_comb begin
    int src;
    ld_1 = in_1;  // words past the top never reach the output
    ld_2 = in_2;
    for (int i = 0; i < UNITS_EDGES; i++) begin
      src = i + KH_MAX / 2 - int'(in.kh2);
      if (src >= 0 && src < UNITS_EDGES) begin
        ld_1[i] = in_1[src];
        ld_2[i] = in_2[src];
      end
    end
  end

  // ****************************************
  // shift count and output valid
  // ****************************************
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (out.ready) begin
      if (cnt_q == '0) begin
        valid_q <= in.valid;
        if (in.valid) begin
          cnt_q <= CNT_BITS'({in.kh2, 1'b0});  // 2*kh2 more beats after this one
        end
      end else begin
        valid_q <= 1'b1;
        cnt_q   <= cnt_q - 1'b1;
      end
    end
  end

  // word buffers, one word down per beat
  always_ff @(posedge aclk) begin
    if (out.ready) begin
      if (cnt_q == '0) begin
        buf_1_q <= ld_1;
        buf_2_q <= ld_2;
        kh2_q   <= in.kh2;
      end else begin
        buf_1_q <= {buf_1_q[UNITS_EDGES-1], buf_1_q[UNITS_EDGES-1:1]};
        buf_2_q <= {buf_2_q[UNITS_EDGES-1], buf_2_q[UNITS_EDGES-1:1]};
      end
    end
  end

  assign in.ready   = out.ready && (cnt_q == '0);  // low while shifting
  assign out.valid  = valid_q;
  assign out.lane_1 = buf_1_q[UNITS-1:0];
  assign out.lane_2 = buf_2_q[UNITS-1:0];
  assign out.kh2    = kh2_q;

endmodule

// ==== rtl/stream_slice.sv ====
// Two-entry register slice

module stream_slice #(
  parameter type lane_t   = logic,
  parameter int  KH2_BITS = image_geom_pkg::kh2_bits(image_geom_pkg::DEF_KH_MAX)
) (
  input  logic         aclk,
  input  logic         arst_n,
  image_beat_if.sink   in,
  image_beat_if.source out
);

  logic                out_valid_q;
  logic                skid_valid_q;
  logic                ready_q;
  lane_t               out_lane_1_q;
  lane_t               out_lane_2_q;
  logic [KH2_BITS-1:0] out_kh2_q;
  lane_t               skid_lane_1_q;
  lane_t               skid_lane_2_q;
  logic [KH2_BITS-1:0] skid_kh2_q;
  logic                in_fire;
  logic                out_free;

  assign in_fire  = in.valid && ready_q;
  assign out_free = !out_valid_q || out.ready;  // output entry can take a beat

  // ****************************************
  // entry valids and registered ready
  // ****************************************
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else if (out_free) begin
      out_valid_q  <= skid_valid_q || in_fire;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;  // both entries full now
      ready_q      <= 1'b0;
    end else begin
      ready_q <= !skid_valid_q;
    end
  end

  // ****************************************
  // payload
  // ****************************************
  always_ff @(posedge aclk) begin
    if (out_free) begin
      out_lane_1_q <= skid_valid_q ? skid_lane_1_q : in.lane_1;
      out_lane_2_q <= skid_valid_q ? skid_lane_2_q : in.lane_2;
      out_kh2_q    <= skid_valid_q ? skid_kh2_q : in.kh2;
    end
    if (!out_free && in_fire) begin
      skid_lane_1_q <= in.lane_1;
      skid_lane_2_q <= in.lane_2;
      skid_kh2_q    <= in.kh2;
    end
  end

  assign in.ready   = ready_q;
  assign out.valid  = out_valid_q;
  assign out.lane_1 = out_lane_1_q;
  assign out.lane_2 = out_lane_2_q;
  assign out.kh2    = out_kh2_q;

endmodule

// ==== rtl/frame_header_ctrl.sv ====
// Frame header control and stream join

module frame_header_ctrl #(
  parameter int UNITS      = image_geom_pkg::DEF_UNITS,
  parameter int KH_MAX     = image_geom_pkg::DEF_KH_MAX,
  parameter int WORD_WIDTH = image_geom_pkg::DEF_WORD_WIDTH
) (
  input  logic                      aclk,
  input  logic                      arst_n,
  input  logic                      s1_valid,
  output logic                      s1_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s1_data,
  input  logic                      s1_last,
  input  logic                      s2_valid,
  output logic                      s2_ready,
  input  logic [WORD_WIDTH*image_geom_pkg::padded_words(UNITS, KH_MAX)-1:0] s2_data,
  image_beat_if.source              out
);

  import image_geom_pkg::*;
  import stream_ctrl_pkg::*;

  localparam int UNITS_EDGES = padded_words(UNITS, KH_MAX);
  localparam int KH2_BITS    = kh2_bits(KH_MAX);

  typedef logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] words_t;

  words_t              s1_words;
  words_t              s2_words;
  frame_state_e        state_q;
  logic                is_max_q;
  logic [KH2_BITS-1:0] kh2_q;
  logic                s1_fire;

  // header words must sit inside one beat
  if (IDX_IS_NOT_MAX >= UNITS_EDGES || IDX_IS_MAX >= UNITS_EDGES ||
      IDX_KH2 >= UNITS_EDGES) begin : g_hdr_check
    $error("header word index beyond beat width");
  end

  assign s1_words = s1_data;  // word i at bits [i*WORD_WIDTH +: WORD_WIDTH]
  assign s2_words = s2_data;
  assign s1_fire  = s1_valid && s1_ready;

  // ****************************************
  // frame state and header registers
  // ****************************************
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= HEADER_S;
      is_max_q <= 1'b0;
      kh2_q    <= '0;
    end else if (s1_fire) begin
      if (state_q == HEADER_S) begin
        state_q  <= PASS_S;
        is_max_q <= s1_words[IDX_IS_MAX][0];
        kh2_q    <= s1_words[IDX_KH2][KH2_BITS-1:0];
      end else if (s1_last) begin
        state_q <= HEADER_S;  // next beat is a new header
      end
    end
  end

  // ****************************************
  // handshake, join or copy
  // ****************************************
  always_comb begin
    out.valid = 1'b0;
    s1_ready  = 1'b0;
    s2_ready  = 1'b0;
    case (state_q)
      HEADER_S: begin
        s1_ready = out.ready;  // header is consumed here
      end
      default: begin
        if (is_max_q) begin
          out.valid = s1_valid && s2_valid;
          s1_ready  = s2_valid && out.ready;
          s2_ready  = s1_valid && out.ready;
        end else begin
          out.valid = s1_valid;
          s1_ready  = out.ready;
        end
      end
    endcase
  end

  assign out.lane_1 = s1_words;
  assign out.lane_2 = is_max_q ? s2_words : s1_words;  // copy stream 1 unless max
  assign out.kh2    = kh2_q;

endmodule

// ==== rtl/image_beat_if.sv ====
// Two-lane image beat interface

interface image_beat_if #(
  parameter type lane_t   = logic,
  parameter int  KH2_BITS = image_geom_pkg::kh2_bits(image_geom_pkg::DEF_KH_MAX)
);

  logic                valid;   // source side
  logic                ready;   // sink side
  logic [KH2_BITS-1:0] kh2;     // kernel height halved, per beat
  lane_t               lane_1;
  lane_t               lane_2;

  // a beat moves on a clock edge with valid and ready both high
  modport source (
    output valid, kh2, lane_1, lane_2,
    input  ready
  );

  modport sink (
    input  valid, kh2, lane_1, lane_2,
    output ready
  );

endinterface

// ==== rtl/stream_ctrl_pkg.sv ====
// Stream control package

package stream_ctrl_pkg;

  // ****************************************
  // header beat layout
  // ****************************************
  localparam int IDX_IS_NOT_MAX = 0;  // reserved word
  localparam int IDX_IS_MAX     = 1;  // lsb selects max mode
  localparam int IDX_KH2        = 3;  // kernel height halved

  // ****************************************
  // frame state
  // ****************************************
  typedef enum logic {
    HEADER_S = 1'b0,  // next s1 beat is a header
    PASS_S   = 1'b1   // data beats of the frame
  } frame_state_e;

endpackage

// ==== rtl/image_geom_pkg.sv ====
// Image geometry package

package image_geom_pkg;

  // ****************************************
  // default geometry
  // ****************************************
  localparam int DEF_WORD_WIDTH = 8;  // bits per pixel word
  localparam int DEF_UNITS      = 4;  // output words per lane
  localparam int DEF_KH_MAX     = 5;  // largest kernel height, odd

  // words per input beat, UNITS plus the edge words on both sides
  function automatic int padded_words(input int units, input int kh_max);
    return units + kh_max - 1;
  endfunction

  // width of kh2, which runs 0 .. kh_max/2
  function automatic int kh2_bits(input int kh_max);
    return (kh_max / 2 < 1) ? 1 : $clog2(kh_max / 2 + 1);
  endfunction

endpackage
